// ==== hdl/can_pkg.sv ====
package can_pkg;

  // Controller register map
  localparam logic [4:0] ADDR_TX_ID   = 5'h0C;
  localparam logic [4:0] ADDR_TX_D12  = 5'h0A;
  localparam logic [4:0] ADDR_TX_D34  = 5'h09;
  localparam logic [4:0] ADDR_TX_D56  = 5'h08;
  localparam logic [4:0] ADDR_TX_D78  = 5'h07;
  localparam logic [4:0] ADDR_TX_CTRL = 5'h0D;
  localparam logic [4:0] ADDR_GENERAL = 5'h0E;
  localparam logic [4:0] ADDR_IRQ     = 5'h12;
  localparam logic [4:0] ADDR_RX_ID   = 5'h06;
  localparam logic [4:0] ADDR_RX_D12  = 5'h05;
  localparam logic [4:0] ADDR_RX_D34  = 5'h04;
  localparam logic [4:0] ADDR_RX_D56  = 5'h03;
  localparam logic [4:0] ADDR_RX_D78  = 5'h02;

  localparam logic [15:0] GEN_WORD     = 16'h009C;  // General control setup
  localparam logic [15:0] IRQ_CLR_WORD = 16'h8070;  // Clears pending interrupts
  localparam logic [15:0] TX_REQ_WORD  = 16'h8000;  // Mailbox goes in bits 4:0

  // Symbolic register operations
  typedef enum logic [3:0] {
    OP_GENERAL,
    OP_IRQ_CLR,
    OP_TX_ID,
    OP_TX_D12,
    OP_TX_D34,
    OP_TX_D56,
    OP_TX_D78,
    OP_TX_CTRL,
    OP_RX_ID,
    OP_RX_D12,
    OP_RX_D34,
    OP_RX_D56,
    OP_RX_D78
  } reg_op_e;

  // data[1] is byte 1, in the top bits
  typedef struct packed {
    logic [10:0]     ident;
    logic [1:8][7:0] data;
    logic [4:0]      mailbox;
  } can_tx_msg_t;

  typedef struct packed {
    logic [10:0]     ident;
    logic [1:8][7:0] data;
  } can_rx_msg_t;

  // One register bus request
  typedef struct packed {
    logic [4:0]  addr;
    logic [15:0] wdata;
    logic        write;
  } reg_req_t;

endpackage

// ==== hdl/can_reg_port.sv ====
`timescale 1ns/1ps
module can_reg_port (
  input  logic                 clock,
  input  logic                 arst_n,
  input  can_pkg::reg_op_e     tx_op,
  input  logic                 tx_op_valid,
  input  can_pkg::can_tx_msg_t tx_msg_hold,
  input  can_pkg::reg_op_e     rx_op,
  input  logic                 rx_op_valid,
  input  logic                 bus_ready,
  input  logic [15:0]          bus_rdata,
  output logic                 tx_op_ready,
  output logic                 rx_op_ready,
  output logic [15:0]          op_rdata,
  output can_pkg::reg_req_t    bus_req,
  output logic                 bus_valid
);
  import can_pkg::*;

  logic    hold_active;  // Stalled transfer still owns the bus
  logic    hold_rx;      // Owner of that transfer
  logic    sel_rx;
  reg_op_e op;

  // Receive side wins unless a stalled transfer is in flight
  assign sel_rx      = hold_active ? hold_rx : rx_op_valid;
  assign op          = sel_rx ? rx_op : tx_op;
  assign bus_valid   = sel_rx ? rx_op_valid : tx_op_valid;
  assign tx_op_ready = !sel_rx && bus_ready;
  assign rx_op_ready = sel_rx && bus_ready;
  assign op_rdata    = bus_rdata;  // Same cycle as the handshake

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      hold_active <= 1'b0;
      hold_rx     <= 1'b0;
    end else begin
      hold_active <= bus_valid && !bus_ready;
      hold_rx     <= sel_rx;
    end
  end

  // Operation to address and data word
  always_comb begin
    bus_req.addr  = ADDR_GENERAL;
    bus_req.wdata = 16'h0000;
    bus_req.write = 1'b1;
    case (op)
      OP_GENERAL: bus_req.wdata = GEN_WORD;
      OP_IRQ_CLR: begin
        bus_req.addr  = ADDR_IRQ;
        bus_req.wdata = IRQ_CLR_WORD;
      end
      OP_TX_ID: begin
        bus_req.addr  = ADDR_TX_ID;
        bus_req.wdata = {tx_msg_hold.ident, 5'b00000};
      end
      OP_TX_D12: begin
        bus_req.addr  = ADDR_TX_D12;
        bus_req.wdata = {tx_msg_hold.data[1], tx_msg_hold.data[2]};
      end
      OP_TX_D34: begin
        bus_req.addr  = ADDR_TX_D34;
        bus_req.wdata = {tx_msg_hold.data[3], tx_msg_hold.data[4]};
      end
      OP_TX_D56: begin
        bus_req.addr  = ADDR_TX_D56;
        bus_req.wdata = {tx_msg_hold.data[5], tx_msg_hold.data[6]};
      end
      OP_TX_D78: begin
        bus_req.addr  = ADDR_TX_D78;
        bus_req.wdata = {tx_msg_hold.data[7], tx_msg_hold.data[8]};
      end
      OP_TX_CTRL: begin
        bus_req.addr  = ADDR_TX_CTRL;
        bus_req.wdata = TX_REQ_WORD | {11'd0, tx_msg_hold.mailbox};
      end
      OP_RX_ID: begin
        bus_req.addr  = ADDR_RX_ID;
        bus_req.write = 1'b0;
      end
      OP_RX_D12: begin
        bus_req.addr  = ADDR_RX_D12;
        bus_req.write = 1'b0;
      end
      OP_RX_D34: begin
        bus_req.addr  = ADDR_RX_D34;
        bus_req.write = 1'b0;
      end
      OP_RX_D56: begin
        bus_req.addr  = ADDR_RX_D56;
        bus_req.write = 1'b0;
      end
      OP_RX_D78: begin
        bus_req.addr  = ADDR_RX_D78;
        bus_req.write = 1'b0;
      end
      default: bus_req.write = 1'b0;
    endcase
  end

  // Request must hold until the controller takes it
  a_stall_stable: assert property (@(posedge clock) disable iff (!arst_n)
    bus_valid && !bus_ready |=> bus_valid && $stable(bus_req))
    else $error("bus_req changed during a stall");

  a_tx_no_read: assert property (@(posedge clock) disable iff (!arst_n)
    tx_op_valid |-> !(tx_op inside {OP_RX_ID, OP_RX_D12, OP_RX_D34, OP_RX_D56, OP_RX_D78}))
    else $error("sequencer issued a read operation");

endmodule

// ==== hdl/can_tx_sequencer.sv ====
`timescale 1ns/1ps
module can_tx_sequencer (
  input  logic                 clock,
  input  logic                 arst_n,
  input  can_pkg::can_tx_msg_t tx_msg,
  input  logic                 tx_valid,
  input  logic                 op_ready,
  output logic                 tx_ready,
  output can_pkg::reg_op_e     tx_op,
  output logic                 tx_op_valid,
  output can_pkg::can_tx_msg_t tx_msg_hold
);
  import can_pkg::*;

  typedef enum logic [3:0] {
    INIT_GEN,
    INIT_IRQ,
    IDLE,
    SEND_ID,
    SEND_D12,
    SEND_D34,
    SEND_D56,
    SEND_D78,
    SEND_CTRL
  } seq_state_e;

  seq_state_e state;
  seq_state_e state_nxt;
  logic       take_msg;

  assign tx_ready    = (state == IDLE);    // Only after both config writes
  assign tx_op_valid = (state != IDLE);
  assign take_msg    = tx_valid && tx_ready;

  always_comb begin
    case (state)
      INIT_GEN:  tx_op = OP_GENERAL;
      INIT_IRQ:  tx_op = OP_IRQ_CLR;
      SEND_ID:   tx_op = OP_TX_ID;
      SEND_D12:  tx_op = OP_TX_D12;
      SEND_D34:  tx_op = OP_TX_D34;
      SEND_D56:  tx_op = OP_TX_D56;
      SEND_D78:  tx_op = OP_TX_D78;
      SEND_CTRL: tx_op = OP_TX_CTRL;
      default:   tx_op = OP_GENERAL;  // No request in IDLE
    endcase
  end

  // One step per accepted transfer
  always_comb begin
    state_nxt = state;
    case (state)
      INIT_GEN: begin
        if (op_ready) state_nxt = INIT_IRQ;
      end
      INIT_IRQ: begin
        if (op_ready) state_nxt = IDLE;
      end
      IDLE: begin
        if (take_msg) state_nxt = SEND_ID;
      end
      SEND_ID: begin
        if (op_ready) state_nxt = SEND_D12;
      end
      SEND_D12: begin
        if (op_ready) state_nxt = SEND_D34;
      end
      SEND_D34: begin
        if (op_ready) state_nxt = SEND_D56;
      end
      SEND_D56: begin
        if (op_ready) state_nxt = SEND_D78;
      end
      SEND_D78: begin
        if (op_ready) state_nxt = SEND_CTRL;
      end
      SEND_CTRL: begin
        if (op_ready) state_nxt = IDLE;  // tx_ready back next cycle
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state <= INIT_GEN;
    end else begin
      state <= state_nxt;
    end
  end

  // Message copy used by the port while the writes run
  always_ff @(posedge clock) begin
    if (take_msg) begin
      tx_msg_hold <= tx_msg;
    end
  end

  // Once a message is taken, no new one until its control write is done
  a_no_ready_busy: assert property (@(posedge clock) disable iff (!arst_n)
    take_msg |=> !tx_ready until_with (tx_op_valid && op_ready && tx_op == OP_TX_CTRL))
    else $error("tx_ready high while a message is still being written");

endmodule

// ==== hdl/can_rx_assembler.sv ====
`timescale 1ns/1ps
module can_rx_assembler (
  input  logic                 clock,
  input  logic                 arst_n,
  input  logic                 rx_pending,
  input  logic                 op_ready,
  input  logic [15:0]          op_rdata,
  input  logic                 rx_ready,
  output can_pkg::reg_op_e     rx_op,
  output logic                 rx_op_valid,
  output can_pkg::can_rx_msg_t rx_msg,
  output logic                 rx_valid
);
  import can_pkg::*;

  typedef enum logic [3:0] {
    IDLE,
    RD_ID,
    RD_D12,
    RD_D34,
    RD_D56,
    RD_D78,
    PRESENT,
    CLEAR,
    WAIT_LOW
  } asm_state_e;

  asm_state_e state;
  asm_state_e state_nxt;
  logic       rd_done;

  assign rx_valid    = (state == PRESENT);
  assign rx_op_valid = state inside {RD_ID, RD_D12, RD_D34, RD_D56, RD_D78, CLEAR};
  assign rd_done     = op_ready && rx_op_valid;

  always_comb begin
    case (state)
      RD_D12:  rx_op = OP_RX_D12;
      RD_D34:  rx_op = OP_RX_D34;
      RD_D56:  rx_op = OP_RX_D56;
      RD_D78:  rx_op = OP_RX_D78;
      CLEAR:   rx_op = OP_IRQ_CLR;
      default: rx_op = OP_RX_ID;
    endcase
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:     if (rx_pending) state_nxt = RD_ID;
      RD_ID:    if (rd_done) state_nxt = RD_D12;
      RD_D12:   if (rd_done) state_nxt = RD_D34;
      RD_D34:   if (rd_done) state_nxt = RD_D56;
      RD_D56:   if (rd_done) state_nxt = RD_D78;
      RD_D78:   if (rd_done) state_nxt = PRESENT;
      PRESENT:  if (rx_ready) state_nxt = CLEAR;   // Clear only after handoff
      CLEAR:    if (rd_done) state_nxt = WAIT_LOW;
      WAIT_LOW: if (!rx_pending) state_nxt = IDLE; // Level must drop first
      default:  state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Read words land in the frame fields
  always_ff @(posedge clock) begin
    if (rd_done) begin
      case (state)
        RD_ID:   rx_msg.ident <= op_rdata[15:5];
        RD_D12:  {rx_msg.data[1], rx_msg.data[2]} <= op_rdata;
        RD_D34:  {rx_msg.data[3], rx_msg.data[4]} <= op_rdata;
        RD_D56:  {rx_msg.data[5], rx_msg.data[6]} <= op_rdata;
        RD_D78:  {rx_msg.data[7], rx_msg.data[8]} <= op_rdata;
        default: ;
      endcase
    end
  end

  a_msg_hold: assert property (@(posedge clock) disable iff (!arst_n)
    rx_valid && !rx_ready |=> rx_valid && $stable(rx_msg))
    else $error("rx_msg changed before the consumer took it");

endmodule

// ==== hdl/can_node_top.sv ====
`timescale 1ns/1ps
module can_node_top (
  input  logic                 clock,
  input  logic                 arst_n,
  input  can_pkg::can_tx_msg_t tx_msg,
  input  logic                 tx_valid,
  input  logic                 rx_ready,
  input  logic                 rx_pending,
  input  logic                 bus_ready,
  input  logic [15:0]          bus_rdata,
  output logic                 tx_ready,
  output can_pkg::can_rx_msg_t rx_msg,
  output logic                 rx_valid,
  output can_pkg::reg_req_t    bus_req,
  output logic                 bus_valid
);
  import can_pkg::*;

  reg_op_e     tx_op;
  logic        tx_op_valid;
  logic        tx_op_ready;
  can_tx_msg_t tx_msg_hold;   // Message under transmission
  reg_op_e     rx_op;
  logic        rx_op_valid;
  logic        rx_op_ready;
  logic [15:0] op_rdata;

  can_tx_sequencer u_tx_seq (
    .clock       (clock),
    .arst_n      (arst_n),
    .tx_msg      (tx_msg),
    .tx_valid    (tx_valid),
    .op_ready    (tx_op_ready),
    .tx_ready    (tx_ready),
    .tx_op       (tx_op),
    .tx_op_valid (tx_op_valid),
    .tx_msg_hold (tx_msg_hold)
  );

  can_rx_assembler u_rx_asm (
    .clock       (clock),
    .arst_n      (arst_n),
    .rx_pending  (rx_pending),
    .op_ready    (rx_op_ready),
    .op_rdata    (op_rdata),
    .rx_ready    (rx_ready),
    .rx_op       (rx_op),
    .rx_op_valid (rx_op_valid),
    .rx_msg      (rx_msg),
    .rx_valid    (rx_valid)
  );

  can_reg_port u_reg_port (
    .clock       (clock),
    .arst_n      (arst_n),
    .tx_op       (tx_op),
    .tx_op_valid (tx_op_valid),
    .tx_msg_hold (tx_msg_hold),
    .rx_op       (rx_op),
    .rx_op_valid (rx_op_valid),
    .bus_ready   (bus_ready),
    .bus_rdata   (bus_rdata),
    .tx_op_ready (tx_op_ready),
    .rx_op_ready (rx_op_ready),
    .op_rdata    (op_rdata),
    .bus_req     (bus_req),
    .bus_valid   (bus_valid)
  );

endmodule

// ==== sim/can_reg_model.sv ====
`timescale 1ns/1ps
module can_reg_model (
  input  logic                 clock,
  input  logic                 arst_n,
  input  can_pkg::reg_req_t    bus_req,
  input  logic                 bus_valid,
  output logic                 bus_ready,
  output logic [15:0]          bus_rdata,
  output logic                 rx_pending,
  input  logic                 load_valid,
  input  can_pkg::can_rx_msg_t load_frame
);
  import can_pkg::*;

  logic [15:0] regs [0:31];
  integer      seed = 11;
  int          n_writes;  // Every accepted write
  logic        wr_fire;

  assign wr_fire   = bus_valid && bus_ready && bus_req.write;
  assign bus_rdata = regs[bus_req.addr];  // Valid in the handshake cycle

  initial begin
    bus_ready  = 1'b0;
    rx_pending = 1'b0;
    for (int a = 0; a < 32; a++) begin
      regs[a] = {3'b101, a[4:0], 3'b010, a[4:0]};  // Address in both halves
    end
  end

  // Random stalls, roughly one cycle in four
  always @(negedge clock) begin
    bus_ready <= ($random(seed) & 3) != 0;
  end

  always @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rx_pending <= 1'b0;
      n_writes   <= 0;
    end else begin
      if (load_valid) begin
        regs[ADDR_RX_ID]  <= {load_frame.ident, 5'b00000};
        regs[ADDR_RX_D12] <= {load_frame.data[1], load_frame.data[2]};
        regs[ADDR_RX_D34] <= {load_frame.data[3], load_frame.data[4]};
        regs[ADDR_RX_D56] <= {load_frame.data[5], load_frame.data[6]};
        regs[ADDR_RX_D78] <= {load_frame.data[7], load_frame.data[8]};
        rx_pending        <= 1'b1;
      end
      if (wr_fire) begin
        regs[bus_req.addr] <= bus_req.wdata;
        n_writes           <= n_writes + 1;
        if (bus_req.addr == ADDR_IRQ && bus_req.wdata == IRQ_CLR_WORD) begin
          rx_pending <= 1'b0;  // Interrupt acknowledged
        end
      end
    end
  end

endmodule

// ==== sim/tb_can_node.sv ====
`timescale 1ns/1ps
module tb_can_node;
  import can_pkg::*;

  logic        clock;
  logic        arst_n;
  can_tx_msg_t tx_msg;
  logic        tx_valid;
  logic        tx_ready;
  can_rx_msg_t rx_msg;
  logic        rx_valid;
  logic        rx_ready;
  logic        rx_pending;
  reg_req_t    bus_req;
  logic        bus_valid;
  logic        bus_ready;
  logic [15:0] bus_rdata;
  logic        load_valid;
  can_rx_msg_t load_frame;

  can_tx_msg_t tx_msgs[$];
  logic [15:0] exp_words[$];   // Six register words per transmit message
  can_rx_msg_t rx_frames[$];
  int          golden_lines = 0;
  int          n_err = 0;
  int          n_init = 0;
  int          n_txw = 0;
  int          n_rx_got = 0;
  int          n_clr = 0;
  int          hold_cnt = 20;  // First frame waits this long for the consumer
  integer      seed = 11;

  can_node_top uut (
    .clock(clock), .arst_n(arst_n), .tx_msg(tx_msg), .tx_valid(tx_valid),
    .rx_ready(rx_ready), .rx_pending(rx_pending), .bus_ready(bus_ready),
    .bus_rdata(bus_rdata), .tx_ready(tx_ready), .rx_msg(rx_msg),
    .rx_valid(rx_valid), .bus_req(bus_req), .bus_valid(bus_valid)
  );

  can_reg_model reg_model (
    .clock(clock), .arst_n(arst_n), .bus_req(bus_req), .bus_valid(bus_valid),
    .bus_ready(bus_ready), .bus_rdata(bus_rdata), .rx_pending(rx_pending),
    .load_valid(load_valid), .load_frame(load_frame)
  );

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [95:0] got, input logic [95:0] exp);
    if (got !== exp) begin
      n_err++;
      stop_with_failure($sformatf("ERROR at %0t ns: %s is %0h, expected %0h",
                                  $time, name, got, exp));
    end
  endtask

  function automatic logic [4:0] tx_step_addr(input int step);
    case (step)
      0:       return ADDR_TX_ID;
      1:       return ADDR_TX_D12;
      2:       return ADDR_TX_D34;
      3:       return ADDR_TX_D56;
      4:       return ADDR_TX_D78;
      default: return ADDR_TX_CTRL;
    endcase
  endfunction

  task automatic read_golden();
    int              fd;
    int              n;
    int              i;
    logic [8*4-1:0]  kind;
    logic [8*128-1:0] skip;
    logic [15:0]     val;
    logic [15:0]     f [0:15];
    can_tx_msg_t     tm;
    can_rx_msg_t     rm;
    fd = $fopen("sim/can_node_golden.txt", "r");
    if (fd == 0) stop_with_failure("Cannot open the golden file sim/can_node_golden.txt");
    while ($fscanf(fd, "%s", kind) == 1) begin
      if (kind == "T" || kind == "R") begin
        for (i = 0; i < ((kind == "T") ? 16 : 9); i++) begin
          n = $fscanf(fd, "%h", val);
          if (n != 1) stop_with_failure("A line of the golden file is incomplete");
          f[i] = val;
        end
        golden_lines++;
        if (kind == "T") begin
          tm.ident = f[0][10:0];
          for (i = 1; i <= 8; i++) tm.data[i] = f[i][7:0];
          tm.mailbox = f[9][4:0];
          tx_msgs.push_back(tm);
          for (i = 10; i < 16; i++) exp_words.push_back(f[i]);
        end else begin
          rm.ident = f[0][10:0];
          for (i = 1; i <= 8; i++) rm.data[i] = f[i][7:0];
          rx_frames.push_back(rm);
        end
      end else begin
        n = $fgets(skip, fd);  // Comment line
      end
    end
    $fclose(fd);
    if (golden_lines == 0) stop_with_failure("The golden file holds no entries");
  endtask

  task automatic send_tx(input can_tx_msg_t msg);
    @(negedge clock);
    tx_msg   = msg;
    tx_valid = 1'b1;
    @(posedge clock);
    while (!tx_ready) @(posedge clock);
    @(negedge clock);
    tx_valid = 1'b0;
  endtask

  task automatic load_rx(input can_rx_msg_t frame);
    @(negedge clock);
    while (rx_pending) @(negedge clock);  // Previous frame must be cleared
    load_frame = frame;
    load_valid = 1'b1;
    @(negedge clock);
    load_valid = 1'b0;
  endtask

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;  // 40 ns period
  end

  // Consumer stalls on the first frame, random afterwards
  always @(negedge clock) begin
    if (hold_cnt > 0) begin
      rx_ready = 1'b0;
      if (rx_valid) hold_cnt--;
    end else begin
      rx_ready = ($random(seed) & 1) != 0;
    end
  end

  always @(posedge clock) begin
    if (arst_n) begin
      if (n_init < 2) check_val("tx_ready", tx_ready, 1'b0);
      if (bus_valid && bus_ready && bus_req.write) begin
        if (n_init < 2) begin
          check_val("bus_req.addr", bus_req.addr, (n_init == 0) ? ADDR_GENERAL : ADDR_IRQ);
          check_val("bus_req.wdata", bus_req.wdata, (n_init == 0) ? GEN_WORD : IRQ_CLR_WORD);
          n_init++;
        end else if (bus_req.addr == ADDR_IRQ) begin
          check_val("bus_req.wdata", bus_req.wdata, IRQ_CLR_WORD);
          check_val("irq clear after rx handshake", n_clr < n_rx_got, 1'b1);
          n_clr++;
        end else begin
          if (n_txw >= exp_words.size()) stop_with_failure("A transmit write came too many");
          check_val("bus_req.addr", bus_req.addr, tx_step_addr(n_txw % 6));
          check_val("bus_req.wdata", bus_req.wdata, exp_words[n_txw]);
          n_txw++;
        end
      end
      if (rx_valid) begin
        if (n_rx_got >= rx_frames.size()) stop_with_failure("An extra frame came out on rx_msg");
        check_val("rx_msg", rx_msg, rx_frames[n_rx_got]);  // Also while held under back-pressure
        if (rx_ready) n_rx_got++;
      end
    end
  end

  // 400 cycles of 40 ns per golden line
  initial begin
    wait (golden_lines > 0);
    #(golden_lines * 400 * 40);
    stop_with_failure("Timeout: the node did not finish all golden entries in time");
  end

  initial begin : main
    int k;
    arst_n     = 1'b0;
    tx_msg     = '0;
    tx_valid   = 1'b0;
    rx_ready   = 1'b0;
    load_valid = 1'b0;
    load_frame = '0;
    read_golden();
    repeat (8) @(posedge clock);
    @(negedge clock);
    arst_n = 1'b1;
    fork
      foreach (tx_msgs[i]) send_tx(tx_msgs[i]);
      begin
        wait (n_init == 2);  // Frames only after the config IRQ clear
        foreach (rx_frames[i]) load_rx(rx_frames[i]);
      end
    join
    wait (n_txw == exp_words.size() && n_rx_got == rx_frames.size()
          && n_clr == rx_frames.size());
    repeat (4) @(posedge clock);
    if (tx_msgs.size() > 0) begin
      for (k = 0; k < 6; k++) begin
        check_val($sformatf("regs[%0h]", tx_step_addr(k)), reg_model.regs[tx_step_addr(k)],
                  exp_words[exp_words.size() - 6 + k]);
      end
    end
    check_val("controller write count", reg_model.n_writes,
              2 + exp_words.size() + rx_frames.size());
    if (n_err == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      stop_with_failure("Checks failed during the run");
    end
  end

endmodule

// ==== verilog.f ====
hdl/can_pkg.sv
hdl/can_reg_port.sv
hdl/can_tx_sequencer.sv
hdl/can_rx_assembler.sv
hdl/can_node_top.sv
sim/can_reg_model.sv
sim/tb_can_node.sv

// ==== sim/can_node_golden.txt ====
# T ident b1 b2 b3 b4 b5 b6 b7 b8 mailbox id_word d12 d34 d56 d78 ctrl_word (all hex)
# R ident b1 b2 b3 b4 b5 b6 b7 b8 (hex), the frame that must come out on rx_msg
T 123 11 22 33 44 55 66 77 88 01 2460 1122 3344 5566 7788 8001
R 1A5 01 23 45 67 89 AB CD EF
T 7FF 00 FF 01 FE 02 FD 03 FC 1F FFE0 00FF 01FE 02FD 03FC 801F
R 000 00 00 00 00 00 00 00 00
T 000 DE AD BE EF CA FE BA BE 00 0000 DEAD BEEF CAFE BABE 8000
R 7FF FF FF FF FF FF FF FF FF
T 555 01 02 03 04 05 06 07 08 0A AAA0 0102 0304 0506 0708 800A
R 3C3 10 20 30 40 50 60 70 80
T 2AA A5 5A C3 3C 96 69 F0 0F 15 5540 A55A C33C 9669 F00F 8015
R 0F0 AA BB CC DD EE FF 11 22
T 001 80 40 20 10 08 04 02 01 03 0020 8040 2010 0804 0201 8003
R 6D2 5A A5 5A A5 0F F0 0F F0
T 400 12 34 56 78 9A BC DE F0 10 8000 1234 5678 9ABC DEF0 8010
R 081 C0 FF EE 00 BA D0 F0 0D
